//--- source/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

////////////////////
// address layout
////////////////////

`define DC_ADDR_W        32        // byte address width
`define DC_SET_BITS      4         // index width, 16 sets

////////////////////
// replacement
////////////////////

`define DC_WAYS          4         // victim logic is written for 4
`define DC_AGE_MAX       15        // ages saturate here

// segment remap for the uncached window
`define DC_UNCACHED_SEG  16'hbfaf
`define DC_PHYS_SEG      16'h1faf

`endif

//--- source/cache_pkg.sv
`include "dcache_cfg.svh"

package cache_pkg;

    // tag is what is left above index and byte offset
    localparam int TAG_W = `DC_ADDR_W - `DC_SET_BITS - 2;

    typedef enum logic [1:0] {
        cpu_exec,   // serving hits, waiting for a miss
        wr_dram,    // victim word going out
        rd_dram     // refill word coming in
    } cache_state_e;

    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [`DC_SET_BITS-1:0] index_t;

    // byte address split for lookup
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        logic [1:0] offset;
    } addr_fields_t;

    typedef logic [$clog2(`DC_WAYS)-1:0]      way_t;
    typedef logic [$clog2(`DC_AGE_MAX+1)-1:0] age_t;
    typedef logic [`DC_WAYS-1:0]              way_vec_t; // one bit per way

endpackage

//--- source/bus_pkg.sv
`include "dcache_cfg.svh"

package bus_pkg;

    typedef enum logic [1:0] {
        sz_byte,
        sz_half,
        sz_word
    } size_e;

    typedef enum logic {
        acc_read,
        acc_write
    } rw_e;

    // same shape on processor and memory side
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
        logic [3:0]            wen;    // byte enables, bit 0 is the low byte
        size_e                 size;
        rw_e                   rw;
    } bus_req_t;

endpackage

//--- source/cache_arrays.sv
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module cache_arrays (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::index_t   index,
    input  logic                refill_en,
    input  cache_pkg::way_t     refill_way,
    input  cache_pkg::tag_t     refill_tag,
    input  logic [31:0]         refill_data,
    input  logic                wr_hit_en,
    input  cache_pkg::way_t     hit_way,
    input  logic [31:0]         wr_data,
    input  logic [3:0]          wr_wen,
    output cache_pkg::way_vec_t way_valid,
    output cache_pkg::way_vec_t way_dirty,
    output cache_pkg::tag_t     way_tags [`DC_WAYS],
    output logic [31:0]         way_data [`DC_WAYS],
    output cache_pkg::age_t     way_ages [`DC_WAYS]
);
    import cache_pkg::*;

    localparam int SETS = 1 << `DC_SET_BITS;

    way_vec_t    valid_q [SETS];
    way_vec_t    dirty_q [SETS];
    age_t        age_q   [SETS][`DC_WAYS];
    tag_t        tag_q   [SETS][`DC_WAYS];
    logic [31:0] data_q  [SETS][`DC_WAYS];

    way_t        touched_way;          // way whose age drops to zero
    age_t        next_age [`DC_WAYS];
    logic [31:0] merged;               // write-hit word after byte merge

    ////////////////////
    // combinational read of the addressed set
    ////////////////////
    always_comb begin
        way_valid = valid_q[index];
        way_dirty = dirty_q[index];
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_tags[w] = tag_q[index][w];
            way_data[w] = data_q[index][w];
            way_ages[w] = age_q[index][w];
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = wr_wen[b] ? wr_data[8*b +: 8] : way_data[hit_way][8*b +: 8];
        end
    end

    // ages count updates since a way was last touched
    assign touched_way = refill_en ? refill_way : hit_way;

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (touched_way == way_t'(w))
                next_age[w] = '0;
            else if (way_ages[w] == age_t'(`DC_AGE_MAX))
                next_age[w] = way_ages[w];            // saturate
            else
                next_age[w] = way_ages[w] + age_t'(1);
        end
    end

    ////////////////////
    // state updates
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                for (int w = 0; w < `DC_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else begin
            if (refill_en) begin
                valid_q[index][refill_way] <= 1'b1;
                dirty_q[index][refill_way] <= 1'b0;   // fresh copy of memory
            end else if (wr_hit_en) begin
                dirty_q[index][hit_way] <= 1'b1;
            end
            if (refill_en || wr_hit_en) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    age_q[index][w] <= next_age[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_en) begin
            tag_q[index][refill_way]  <= refill_tag;
            data_q[index][refill_way] <= refill_data;
        end else if (wr_hit_en) begin
            data_q[index][hit_way] <= merged;
        end
    end

    // the controller never refills and write-hits in one cycle
    a_no_dual_update: assert property (@(posedge clk) disable iff (rst)
        !(refill_en && wr_hit_en))
        else $error("refill and write hit in the same cycle");

endmodule

//--- source/cache_lookup.sv
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module cache_lookup (
    input  cache_pkg::tag_t     tag,
    input  cache_pkg::way_vec_t way_valid,
    input  cache_pkg::tag_t     way_tags [`DC_WAYS],
    input  logic [31:0]         way_data [`DC_WAYS],
    output logic                hit,
    output cache_pkg::way_t     hit_way,
    output logic [31:0]         hit_data
);
    import cache_pkg::*;

    way_vec_t match;    // valid and tag equal, per way

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = way_valid[w] && (way_tags[w] == tag);
        end
    end

    // lowest matching way wins
    always_comb begin
        hit_way = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (match[w])
                hit_way = way_t'(w);
        end
    end

    assign hit      = |match;
    assign hit_data = way_data[hit_way];   // way 0 word when nothing hits

    // a refill only happens after a miss, so one set never holds a tag twice
    always_comb begin
        a_single_match: assert ($onehot0(match))
            else $error("tag matches more than one way");
    end

endmodule

//--- source/victim_select.sv
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module victim_select (
    input  cache_pkg::index_t   index,
    input  cache_pkg::way_vec_t way_valid,
    input  cache_pkg::way_vec_t way_dirty,
    input  cache_pkg::age_t     way_ages [`DC_WAYS],
    input  cache_pkg::tag_t     way_tags [`DC_WAYS],
    input  logic [31:0]         way_data [`DC_WAYS],
    output cache_pkg::way_t     victim_way,
    output logic                victim_dirty,
    output logic [31:0]         wb_addr,
    output logic [31:0]         wb_data
);
    import cache_pkg::*;

    logic         inv_found;
    way_t         inv_way;
    logic         clean_found;
    way_t         clean_way;
    age_t         clean_age;
    way_t         old_way;
    age_t         old_age;
    addr_fields_t wb_fields;

    ////////////////////
    // three candidates, scanned low to high
    ////////////////////
    always_comb begin
        inv_found   = 1'b0;
        inv_way     = '0;
        clean_found = 1'b0;
        clean_way   = '0;
        clean_age   = '0;
        old_way     = '0;
        old_age     = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (!way_valid[w] && !inv_found) begin
                inv_found = 1'b1;
                inv_way   = way_t'(w);
            end
            // strict compare keeps ties on the lower way
            if (!way_dirty[w] && (!clean_found || way_ages[w] > clean_age)) begin
                clean_found = 1'b1;
                clean_way   = way_t'(w);
                clean_age   = way_ages[w];
            end
            if (way_ages[w] > old_age) begin
                old_way = way_t'(w);
                old_age = way_ages[w];
            end
        end
    end

    assign victim_way   = inv_found ? inv_way : (clean_found ? clean_way : old_way);
    assign victim_dirty = !inv_found && !clean_found;   // every way dirty

    // write-back goes to the word the victim came from
    assign wb_fields = '{tag: way_tags[victim_way], index: index, offset: 2'b00};
    assign wb_addr   = wb_fields;
    assign wb_data   = way_data[victim_way];

endmodule

//--- source/miss_fsm.sv
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module miss_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cached_strobe,
    input  bus_pkg::bus_req_t       req,
    input  logic                    hit,
    input  logic                    victim_dirty,
    input  logic [31:0]             wb_addr,
    input  logic [31:0]             wb_data,
    input  logic                    m_ready,
    output cache_pkg::cache_state_e state,
    output logic                    refill_en,
    output logic                    wr_hit_en,
    output bus_pkg::bus_req_t       mem_req,
    output logic                    mem_strobe
);
    import cache_pkg::*;
    import bus_pkg::*;

    cache_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            cpu_exec: if (cached_strobe && !hit)
                          next_state = victim_dirty ? wr_dram : rd_dram;
            wr_dram:  if (m_ready)
                          next_state = rd_dram;    // write-back done, fetch line
            rd_dram:  if (m_ready)
                          next_state = cpu_exec;
            default:  next_state = cpu_exec;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= cpu_exec;
        else
            state <= next_state;
    end

    assign refill_en  = (state == rd_dram) && m_ready;
    assign wr_hit_en  = (state == cpu_exec) && cached_strobe && hit && (req.rw == acc_write);
    assign mem_strobe = (state != cpu_exec);

    ////////////////////
    // memory request, always a full word
    ////////////////////
    always_comb begin
        mem_req.size = sz_word;
        if (state == wr_dram) begin
            mem_req.addr  = wb_addr;
            mem_req.wdata = wb_data;
            mem_req.wen   = 4'b1111;
            mem_req.rw    = acc_write;
        end else begin
            mem_req.addr  = {req.addr[`DC_ADDR_W-1:2], 2'b00};
            mem_req.wdata = '0;
            mem_req.wen   = 4'b0000;
            mem_req.rw    = acc_read;
        end
    end

    // request waits unchanged until memory takes it
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_strobe && !m_ready) |=> $stable(mem_req))
        else $error("memory request changed before m_ready");

endmodule

//--- source/d_cache.sv
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module d_cache (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::bus_req_t p_req,
    input  logic              p_strobe,
    output logic [31:0]       p_din,
    output logic              p_ready,
    output bus_pkg::bus_req_t m_req,
    output logic              m_strobe,
    input  logic [31:0]       m_dout,
    input  logic              m_ready
);
    import cache_pkg::*;
    import bus_pkg::*;

    addr_fields_t fields;
    logic         uncached;
    logic         cached_strobe;
    bus_req_t     byp_req;          // processor request moved to the physical segment

    way_vec_t     way_valid;
    way_vec_t     way_dirty;
    tag_t         way_tags [`DC_WAYS];
    logic [31:0]  way_data [`DC_WAYS];
    age_t         way_ages [`DC_WAYS];

    logic         hit;
    way_t         hit_way;
    logic [31:0]  hit_data;
    way_t         victim_way;
    logic         victim_dirty;
    logic [31:0]  wb_addr;
    logic [31:0]  wb_data;

    cache_state_e state;
    logic         refill_en;
    logic         wr_hit_en;
    bus_req_t     fsm_req;
    logic         fsm_strobe;

    ////////////////////
    // uncached decode and bypass
    ////////////////////
    assign fields        = p_req.addr;
    assign uncached      = (p_req.addr[`DC_ADDR_W-1:16] == `DC_UNCACHED_SEG);
    assign cached_strobe = p_strobe && !uncached;

    always_comb begin
        byp_req = p_req;   // size passes through only here
        byp_req.addr[`DC_ADDR_W-1:16] = `DC_PHYS_SEG;
    end

    assign m_req    = uncached ? byp_req : fsm_req;
    assign m_strobe = uncached ? p_strobe : fsm_strobe;
    assign p_din    = uncached ? m_dout : hit_data;
    assign p_ready  = uncached ? (p_strobe && m_ready)
                               : (cached_strobe && hit && state == cpu_exec);

    cache_arrays i_arrays (
        .clk         (clk),
        .rst         (rst),
        .index       (fields.index),
        .refill_en   (refill_en),
        .refill_way  (victim_way),
        .refill_tag  (fields.tag),
        .refill_data (m_dout),
        .wr_hit_en   (wr_hit_en),
        .hit_way     (hit_way),
        .wr_data     (p_req.wdata),
        .wr_wen      (p_req.wen),
        .way_valid   (way_valid),
        .way_dirty   (way_dirty),
        .way_tags    (way_tags),
        .way_data    (way_data),
        .way_ages    (way_ages)
    );

    cache_lookup i_lookup (
        .tag       (fields.tag),
        .way_valid (way_valid),
        .way_tags  (way_tags),
        .way_data  (way_data),
        .hit       (hit),
        .hit_way   (hit_way),
        .hit_data  (hit_data)
    );

    victim_select i_victim (
        .index        (fields.index),
        .way_valid    (way_valid),
        .way_dirty    (way_dirty),
        .way_ages     (way_ages),
        .way_tags     (way_tags),
        .way_data     (way_data),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data)
    );

    miss_fsm i_fsm (
        .clk           (clk),
        .rst           (rst),
        .cached_strobe (cached_strobe),
        .req           (p_req),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .m_ready       (m_ready),
        .state         (state),
        .refill_en     (refill_en),
        .wr_hit_en     (wr_hit_en),
        .mem_req       (fsm_req),
        .mem_strobe    (fsm_strobe)
    );

endmodule

//--- tb/dram_model.sv
`timescale 1ns/10ps

module dram_model #(
    parameter logic [31:0] SEED = 32'ha91693bf
) (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::bus_req_t req,
    input  logic              strobe,
    output logic [31:0]       dout,
    output logic              ready
);
    import bus_pkg::*;

    logic [31:0] mem [logic [31:0]];   // only words that were written
    logic [31:0] lfsr;
    logic [31:0] lfsr_1;
    logic [31:0] lfsr_2;
    logic [1:0]  delay;                // wait cycles for the current transfer
    logic [1:0]  waited;
    logic [31:0] word_addr;
    logic [31:0] merged;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    assign word_addr = {req.addr[31:2], 2'b00};
    assign ready     = strobe && (waited == delay);
    assign lfsr_1    = lfsr_next(lfsr);
    assign lfsr_2    = lfsr_next(lfsr_1);

    // unwritten words read back as address xor a fixed mask
    always_comb begin
        if (mem.exists(word_addr))
            dout = mem[word_addr];
        else
            dout = word_addr ^ 32'h5a5a_0000;
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = req.wen[b] ? req.wdata[8*b +: 8] : dout[8*b +: 8];
        end
    end

    ////////////////////
    // ready latency
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr   <= SEED;
            delay  <= '0;
            waited <= '0;
        end else if (strobe && ready) begin
            waited <= '0;
            delay  <= {lfsr[0], lfsr_1[0]};   // two bits, two steps
            lfsr   <= lfsr_2;
        end else if (strobe) begin
            waited <= waited + 2'd1;
        end
    end

    always @(posedge clk) begin
        if (!rst && strobe && ready && req.rw == acc_write)
            mem[word_addr] = merged;
    end

endmodule

//--- tb/tb_d_cache.sv
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module tb_d_cache;
    import bus_pkg::*;

    localparam int ACCESS_MAX  = 300;
    localparam int CYCLE_LIMIT = ACCESS_MAX * 12;   // dirty miss with slow memory fits in 12

    logic        clk;
    logic        rst;
    bus_req_t    p_req;
    logic        p_strobe;
    logic [31:0] p_din;
    logic        p_ready;
    bus_req_t    m_req;
    logic        m_strobe;
    logic [31:0] m_dout;
    logic        m_ready;

    logic [31:0] lfsr;
    logic [7:0]  shadow [logic [31:0]];   // written bytes by physical address
    logic [31:0] exp_din;
    logic        exp_hit;
    size_e       req_size;                // size driven with the next access
    logic        done_q = 1'b0;
    logic        unc;
    logic        evict_on;
    logic [31:0] evict_addr [5];
    logic        wb_target_ok;
    logic        wb_seen = 1'b0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          cycles = 0;

    d_cache i_dut (
        .clk      (clk),
        .rst      (rst),
        .p_req    (p_req),
        .p_strobe (p_strobe),
        .p_din    (p_din),
        .p_ready  (p_ready),
        .m_req    (m_req),
        .m_strobe (m_strobe),
        .m_dout   (m_dout),
        .m_ready  (m_ready)
    );

    dram_model i_mem (
        .clk    (clk),
        .rst    (rst),
        .req    (m_req),
        .strobe (m_strobe),
        .dout   (m_dout),
        .ready  (m_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, an access never completed", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    always @(posedge clk) done_q <= p_strobe && p_ready;   // seen at the next falling edge

    assign unc = (p_req.addr[31:16] == `DC_UNCACHED_SEG);

    always_comb begin
        wb_target_ok = 1'b0;
        for (int k = 0; k < 5; k++) begin
            if (evict_on && m_req.addr == evict_addr[k])
                wb_target_ok = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (m_strobe && m_ready && !unc && m_req.rw == acc_write)
            wb_seen <= 1'b1;
    end

    ////////////////////
    // checks
    ////////////////////
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !p_strobe |-> (!m_strobe && !p_ready))
        else begin
            other_errors++;
            $display("bus active at %0t while the processor is idle", $time);
        end

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        (p_strobe && p_ready && p_req.rw == acc_read) |-> (p_din == exp_din))
        else begin
            mismatches++;
            $display("MISMATCH at %0t: p_din got %h expected %h",
                     $time, $sampled(p_din), $sampled(exp_din));
        end

    a_hit_fast: assert property (@(posedge clk) disable iff (rst)
        (p_strobe && exp_hit) |-> (p_ready && !m_strobe))
        else begin
            other_errors++;
            $display("repeated read at %0t did not hit in its first cycle", $time);
        end

    a_wb_target: assert property (@(posedge clk) disable iff (rst)
        (m_strobe && !unc && m_req.rw == acc_write) |-> wb_target_ok)
        else begin
            other_errors++;
            $display("write-back at %0t to %h is not a line of the eviction set",
                     $time, $sampled(m_req.addr));
        end

    a_uncached_strobe: assert property (@(posedge clk) disable iff (rst)
        (p_strobe && unc) |-> m_strobe)
        else begin
            other_errors++;
            $display("uncached access at %0t reached no memory strobe", $time);
        end

    a_uncached_addr: assert property (@(posedge clk) disable iff (rst)
        (p_strobe && unc) |-> (m_req.addr == {`DC_PHYS_SEG, p_req.addr[15:0]}))
        else begin
            mismatches++;
            $display("MISMATCH at %0t: m_req.addr got %h expected %h", $time,
                     $sampled(m_req.addr), {`DC_PHYS_SEG, $sampled(p_req.addr[15:0])});
        end

    a_uncached_size: assert property (@(posedge clk) disable iff (rst)
        (p_strobe && unc) |-> (m_req.size == p_req.size))
        else begin
            mismatches++;
            $display("MISMATCH at %0t: m_req.size got %0d expected %0d", $time,
                     $sampled(m_req.size), $sampled(p_req.size));
        end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [31:0] phys_addr(input logic [31:0] addr);
        if (addr[31:16] == `DC_UNCACHED_SEG)
            return {`DC_PHYS_SEG, addr[15:0]};
        return addr;
    endfunction

    function automatic logic [31:0] expect_word(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] word;
        base = {addr[31:2], 2'b00};
        word = base ^ 32'h5a5a_0000;   // memory contents before any write
        for (int b = 0; b < 4; b++) begin
            if (shadow.exists(base + 32'(b)))
                word[8*b +: 8] = shadow[base + 32'(b)];
        end
        return word;
    endfunction

    // called on a falling edge, returns on the falling edge after p_ready
    task automatic run_access(input logic [31:0] addr, input rw_e rw, input logic [31:0] wdata,
                              input logic [3:0] wen, input logic hit_expected);
        logic [31:0] pa;
        pa          = phys_addr(addr);
        p_req.addr  = addr;
        p_req.wdata = wdata;
        p_req.wen   = wen;
        p_req.size  = req_size;
        p_req.rw    = rw;
        exp_din     = expect_word(pa);
        exp_hit     = hit_expected;
        p_strobe    = 1'b1;
        do begin
            @(negedge clk);
        end while (!done_q);
        p_strobe = 1'b0;
        exp_hit  = 1'b0;
        if (rw == acc_write) begin
            for (int b = 0; b < 4; b++) begin
                if (wen[b])
                    shadow[pa + 32'(b)] = wdata[8*b +: 8];
            end
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        lfsr     = 32'ha91693bf;
        p_req    = '0;
        p_strobe = 1'b0;
        exp_din  = '0;
        exp_hit  = 1'b0;
        req_size = sz_word;
        evict_on = 1'b0;
        for (int k = 0; k < 5; k++) begin
            evict_addr[k] = 32'h0010_0030 + 32'(k << 12);   // five tags at index 12
        end
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);

        // first read misses, the repeat hits
        for (int i = 0; i < 8; i++) begin
            a = (i < 4 ? 32'h0002_0000 : 32'h0003_0000) + 32'(4 * (8 + i % 4));
            run_access(a, acc_read, '0, '0, 1'b0);
            run_access(a, acc_read, '0, '0, 1'b1);
        end
        repeat (2) @(negedge clk);

        // two tags over indexes 0 to 7, so no eviction here
        for (int i = 0; i < 96; i++) begin
            take_bits(4, r);
            a = 32'h0004_0000 | (32'(r[3]) << 8) | (32'(r[2:0]) << 2);
            take_bits(1, r);
            if (r[0]) begin
                take_bits(32, d);
                take_bits(4, r);
                run_access(a, acc_write, d, r[3:0], 1'b0);
            end else begin
                run_access(a, acc_read, '0, '0, 1'b0);
            end
        end
        for (int i = 0; i < 16; i++) begin
            a = 32'h0004_0000 | (32'(i >> 3) << 8) | (32'(i % 8) << 2);
            run_access(a, acc_read, '0, '0, 1'b0);
        end
        repeat (2) @(negedge clk);

        evict_on = 1'b1;
        for (int k = 0; k < 5; k++) begin
            take_bits(32, d);
            run_access(evict_addr[k], acc_write, d, 4'hf, 1'b0);
        end
        for (int k = 0; k < 5; k++) begin
            run_access(evict_addr[k], acc_read, '0, '0, 1'b0);
        end
        repeat (2) @(negedge clk);
        evict_on = 1'b0;
        a_wb_happened: assert (wb_seen)
            else begin
                other_errors++;
                $display("no write-back to memory during the eviction test");
            end

        // bypass forwards the size, so walk through all three
        for (int i = 0; i < 4; i++) begin
            a        = {`DC_UNCACHED_SEG, 16'h0100 + 16'(4 * i)};
            req_size = size_e'(i % 3);
            run_access(a, acc_read, '0, '0, 1'b0);
            take_bits(32, d);
            take_bits(4, r);
            run_access(a, acc_write, d, r[3:0], 1'b0);
            run_access(a, acc_read, '0, '0, 1'b0);
        end
        req_size = sz_word;
        repeat (2) @(negedge clk);

        $display("%0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/cache_pkg.sv
source/bus_pkg.sv
source/cache_arrays.sv
source/cache_lookup.sv
source/victim_select.sv
source/miss_fsm.sv
source/d_cache.sv
tb/dram_model.sv
tb/tb_d_cache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_d_cache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
